// File: verilog/fpu_f32_pkg.sv
/* Single-precision format: field struct, word union,
   exponent constants and operand class enum */

package fpu_f32_pkg;

	// ====================
	// Format constants
	// ====================

	// Exponent bias of the single-precision format
	localparam int F32_EXP_BIAS = 127;
	// All-ones exponent marks infinity and NaN
	localparam int F32_EXP_MAX = 255;

	// ====================
	// Word layout
	// ====================

	// Fields of a single-precision word, MSB first
	typedef struct packed {
		logic        sign;
		logic [7:0]  exponent;
		logic [22:0] mantissa;
	} f32_fields_t;

	// Same 32 bits, read as a raw word or as fields
	typedef union packed {
		logic [31:0] raw;
		f32_fields_t fields;
	} f32_t;

	// Operand class after decode
	// Denormals are folded into zero
	typedef enum logic [2:0] {
		F32_CLASS_ZERO   = 3'd0,
		F32_CLASS_NORMAL = 3'd1,
		F32_CLASS_INF    = 3'd2,
		F32_CLASS_QNAN   = 3'd3,
		F32_CLASS_SNAN   = 3'd4
	} f32_class_t;

endpackage

// File: verilog/fpu_op_pkg.sv
/* Operation code, exception flags and canonical NaN */

package fpu_op_pkg;

	// Add, or subtract B from A
	typedef enum logic {
		FPU_OP_ADD = 1'b0,
		FPU_OP_SUB = 1'b1
	} fpu_op_t;

	// Exception flags reported with every result
	typedef struct packed {
		logic invalid;
		logic overflow;
		logic underflow;
		logic inexact;
	} fpu_flags_t;

	// Quiet NaN returned for every NaN result
	localparam logic [31:0] F32_CANON_NAN = 32'h7FC0_0000;

endpackage

// File: verilog/fpu_f32_decode.sv
/* Decode stage: sub sign flip, denormal flush, classing,
   special result selection and significand unpack */
`timescale 1ns/1ps

module fpu_f32_decode
	import fpu_f32_pkg::*, fpu_op_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  logic        in_valid,
	input  fpu_op_t     op,
	input  f32_t        a,
	input  f32_t        b,
	output logic        dec_valid,
	output logic        dec_sign_a,
	output logic        dec_sign_b,
	output logic [7:0]  dec_exp_a,
	output logic [7:0]  dec_exp_b,
	output logic [23:0] dec_sig_a,
	output logic [23:0] dec_sig_b,
	output logic        dec_special,
	output f32_t        dec_special_word,
	output fpu_flags_t  dec_flags
);

	f32_t       b_eff;
	f32_class_t cls_a;
	f32_class_t cls_b;
	logic       snan_any;
	logic       nan_any;
	logic       inf_clash;
	logic       spec;
	f32_t       spec_word;
	fpu_flags_t spec_flags;

	// Class of one operand, denormals count as zero
	function automatic f32_class_t classify(input f32_t v);
		if (v.fields.exponent == 8'(F32_EXP_MAX)) begin
			if (v.fields.mantissa == '0)
				return F32_CLASS_INF;
			// MSB of the mantissa set means quiet
			return v.fields.mantissa[22] ? F32_CLASS_QNAN : F32_CLASS_SNAN;
		end
		if (v.fields.exponent == '0)
			return F32_CLASS_ZERO;
		return F32_CLASS_NORMAL;
	endfunction

	// Subtraction is addition with B negated
	always_comb begin
		b_eff = b;
		b_eff.fields.sign = b.fields.sign ^ (op == FPU_OP_SUB);
	end

	assign cls_a = classify(a);
	assign cls_b = classify(b_eff);

	assign snan_any = (cls_a == F32_CLASS_SNAN) || (cls_b == F32_CLASS_SNAN);
	assign nan_any = snan_any || (cls_a == F32_CLASS_QNAN) || (cls_b == F32_CLASS_QNAN);
	// Opposite infinities cancel into an invalid result
	assign inf_clash = (cls_a == F32_CLASS_INF) && (cls_b == F32_CLASS_INF) &&
		(a.fields.sign != b_eff.fields.sign);

	// ====================
	// Special results
	// ====================
	always_comb begin
		spec = 1'b1;
		spec_word = '0;
		spec_flags = '0;
		if (nan_any || inf_clash) begin
			spec_word.raw = F32_CANON_NAN;
			// Quiet NaN input propagates silently
			spec_flags.invalid = snan_any || inf_clash;
		end else if (cls_a == F32_CLASS_INF) begin
			spec_word.fields.sign = a.fields.sign;
			spec_word.fields.exponent = 8'(F32_EXP_MAX);
		end else if (cls_b == F32_CLASS_INF) begin
			spec_word.fields.sign = b_eff.fields.sign;
			spec_word.fields.exponent = 8'(F32_EXP_MAX);
		end else begin
			spec = 1'b0;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dec_valid <= 1'b0;
			dec_sign_a <= 1'b0;
			dec_sign_b <= 1'b0;
			dec_exp_a <= '0;
			dec_exp_b <= '0;
			dec_sig_a <= '0;
			dec_sig_b <= '0;
			dec_special <= 1'b0;
			dec_special_word <= '0;
			dec_flags <= '0;
		end else begin
			dec_valid <= in_valid;
			dec_sign_a <= a.fields.sign;
			dec_sign_b <= b_eff.fields.sign;
			// Zero class gets exponent 0 and no hidden bit
			dec_exp_a <= (cls_a == F32_CLASS_ZERO) ? 8'd0 : a.fields.exponent;
			dec_exp_b <= (cls_b == F32_CLASS_ZERO) ? 8'd0 : b_eff.fields.exponent;
			dec_sig_a <= (cls_a == F32_CLASS_ZERO) ? 24'd0 : {1'b1, a.fields.mantissa};
			dec_sig_b <= (cls_b == F32_CLASS_ZERO) ? 24'd0 : {1'b1, b_eff.fields.mantissa};
			dec_special <= spec;
			dec_special_word <= spec_word;
			dec_flags <= spec_flags;
		end
	end

endmodule

// File: verilog/fpu_f32_execute.sv
/* Execute stage: magnitude swap, alignment shift with sticky,
   significand add or subtract */
`timescale 1ns/1ps

module fpu_f32_execute
	import fpu_f32_pkg::*, fpu_op_pkg::*;
#(
	parameter int GUARD_BITS = 3
) (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   dec_valid,
	input  logic                   dec_sign_a,
	input  logic                   dec_sign_b,
	input  logic [7:0]             dec_exp_a,
	input  logic [7:0]             dec_exp_b,
	input  logic [23:0]            dec_sig_a,
	input  logic [23:0]            dec_sig_b,
	input  logic                   dec_special,
	input  f32_t                   dec_special_word,
	input  fpu_flags_t             dec_flags,
	output logic                   exe_valid,
	output logic                   exe_sign,
	output logic signed [9:0]      exe_exp,
	output logic [24+GUARD_BITS:0] exe_sum,
	output logic                   exe_special,
	output f32_t                   exe_special_word,
	output fpu_flags_t             exe_flags
);

	// Significand plus guard field
	localparam int SW = 24 + GUARD_BITS;

	logic          a_big;
	logic          big_sign;
	logic [7:0]    big_exp;
	logic [23:0]   big_sig;
	logic [7:0]    small_exp;
	logic [23:0]   small_sig;
	logic [7:0]    exp_diff;
	logic [SW-1:0] small_ext;
	logic [SW-1:0] shifted;
	logic [SW-1:0] lost_mask;
	logic          sticky;
	logic [SW-1:0] aligned;
	logic          eff_sub;
	logic [SW:0]   sum;
	logic          sum_sign;

	// ====================
	// Operand ordering
	// ====================
	// Exponent then significand gives magnitude order
	assign a_big = {dec_exp_a, dec_sig_a} >= {dec_exp_b, dec_sig_b};

	assign big_sign = a_big ? dec_sign_a : dec_sign_b;
	assign big_exp = a_big ? dec_exp_a : dec_exp_b;
	assign big_sig = a_big ? dec_sig_a : dec_sig_b;
	assign small_exp = a_big ? dec_exp_b : dec_exp_a;
	assign small_sig = a_big ? dec_sig_b : dec_sig_a;
	assign exp_diff = big_exp - small_exp;

	// ====================
	// Alignment
	// ====================
	always_comb begin
		small_ext = {small_sig, {GUARD_BITS{1'b0}}};
		lost_mask = '0;
		if (exp_diff >= SW) begin
			// Whole operand falls below the guard field
			shifted = '0;
			sticky = |small_sig;
		end else begin
			shifted = small_ext >> exp_diff;
			lost_mask = (SW'(1) << exp_diff) - SW'(1);
			sticky = |(small_ext & lost_mask);
		end
	end

	// Sticky folds into the lowest guard bit
	assign aligned = {shifted[SW-1:1], shifted[0] | sticky};

	// Unlike signs subtract, big minus small never goes negative
	assign eff_sub = dec_sign_a ^ dec_sign_b;
	assign sum = eff_sub ? ({1'b0, big_sig, {GUARD_BITS{1'b0}}} - {1'b0, aligned}) :
		({1'b0, big_sig, {GUARD_BITS{1'b0}}} + {1'b0, aligned});

	// Exact cancellation is +0
	assign sum_sign = (eff_sub && sum == '0) ? 1'b0 : big_sign;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			exe_valid <= 1'b0;
			exe_sign <= 1'b0;
			exe_exp <= '0;
			exe_sum <= '0;
			exe_special <= 1'b0;
			exe_special_word <= '0;
			exe_flags <= '0;
		end else begin
			exe_valid <= dec_valid;
			exe_sign <= sum_sign;
			// Exponent travels unbiased from here on
			exe_exp <= 10'(big_exp) - 10'(F32_EXP_BIAS);
			exe_sum <= sum;
			exe_special <= dec_special;
			exe_special_word <= dec_special_word;
			exe_flags <= dec_flags;
		end
	end

endmodule

// File: verilog/fpu_f32_result.sv
/* Result stage: normalize, round to nearest even,
   overflow and underflow handling, pack */
`timescale 1ns/1ps

module fpu_f32_result
	import fpu_f32_pkg::*, fpu_op_pkg::*;
#(
	parameter int GUARD_BITS = 3
) (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   exe_valid,
	input  logic                   exe_sign,
	input  logic signed [9:0]      exe_exp,
	input  logic [24+GUARD_BITS:0] exe_sum,
	input  logic                   exe_special,
	input  f32_t                   exe_special_word,
	input  fpu_flags_t             exe_flags,
	output logic                   out_valid,
	output f32_t                   result,
	output fpu_flags_t             flags
);

	// Sum width, and width once the carry bit is gone
	localparam int SW = 25 + GUARD_BITS;
	localparam int NW = SW - 1;
	localparam int LZW = $clog2(NW + 1);

	logic [LZW-1:0]     lz;
	logic [NW-1:0]      norm;
	logic signed [10:0] exp_adj;
	logic signed [10:0] e_norm;
	logic signed [10:0] e_final;
	logic [23:0]        keep;
	logic               guard_bit;
	logic               rest_bits;
	logic               round_up;
	logic               lost_bits;
	logic [24:0]        rounded;
	logic [22:0]        mant_out;
	f32_t               word;
	fpu_flags_t         word_flags;

	// Zeros above the first set bit
	function automatic logic [LZW-1:0] count_lz(input logic [NW-1:0] v);
		logic [LZW-1:0] n;
		logic           found;
		n = '0;
		found = 1'b0;
		for (int i = NW - 1; i >= 0; i--) begin
			if (v[i])
				found = 1'b1;
			else if (!found)
				n = n + 1'b1;
		end
		return n;
	endfunction

	// ====================
	// Normalization
	// ====================
	assign lz = count_lz(exe_sum[NW-1:0]);

	always_comb begin
		if (exe_sum[SW-1]) begin
			// Carry out, one step right keeping sticky
			norm = {exe_sum[SW-1:2], exe_sum[1] | exe_sum[0]};
			exp_adj = 11'sd1;
		end else begin
			norm = exe_sum[NW-1:0] << lz;
			exp_adj = -$signed(11'(lz));
		end
	end

	// ====================
	// Rounding
	// ====================
	assign keep = norm[NW-1:GUARD_BITS];
	assign guard_bit = norm[GUARD_BITS-1];
	// Extra guard bits beyond round all act as sticky
	assign rest_bits = |norm[GUARD_BITS-2:0];
	// Ties go to the even significand
	assign round_up = guard_bit & (rest_bits | keep[0]);
	assign lost_bits = guard_bit | rest_bits;
	assign rounded = {1'b0, keep} + 25'(round_up);
	// Round carry leaves 1.000..., low bits already zero
	assign mant_out = rounded[22:0];

	assign e_norm = 11'(exe_exp + F32_EXP_BIAS + exp_adj);
	assign e_final = e_norm + {10'd0, rounded[24]};

	// Packing and range checks
	always_comb begin
		word = '0;
		word_flags = '0;
		if (exe_special) begin
			word = exe_special_word;
			word_flags = exe_flags;
		end else if (exe_sum == '0) begin
			word.fields.sign = exe_sign;
		end else if (e_final >= F32_EXP_MAX) begin
			word.fields.sign = exe_sign;
			word.fields.exponent = 8'(F32_EXP_MAX);
			word_flags.overflow = 1'b1;
			word_flags.inexact = 1'b1;
		end else if (e_final < 1) begin
			// Too small for a normal, flush to signed zero
			word.fields.sign = exe_sign;
			word_flags.underflow = 1'b1;
		end else begin
			word.fields.sign = exe_sign;
			word.fields.exponent = e_final[7:0];
			word.fields.mantissa = mant_out;
			word_flags.inexact = lost_bits;
		end
	end

	// Idle cycles show zero result and no flags
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
			result <= '0;
			flags <= '0;
		end else begin
			out_valid <= exe_valid;
			result <= exe_valid ? word : '0;
			flags <= exe_valid ? word_flags : '0;
		end
	end

endmodule

// File: verilog/fpu_f32_add.sv
/* Three-stage f32 add/sub pipeline top */
`timescale 1ns/1ps

module fpu_f32_add
	import fpu_f32_pkg::*, fpu_op_pkg::*;
#(
	parameter int GUARD_BITS = 3
) (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       in_valid,
	input  fpu_op_t    op,
	input  f32_t       a,
	input  f32_t       b,
	output logic       out_valid,
	output f32_t       result,
	output fpu_flags_t flags
);

	// ====================
	// Decode to execute
	// ====================
	logic        dec_valid;
	logic        dec_sign_a;
	logic        dec_sign_b;
	logic [7:0]  dec_exp_a;
	logic [7:0]  dec_exp_b;
	logic [23:0] dec_sig_a;
	logic [23:0] dec_sig_b;
	logic        dec_special;
	f32_t        dec_special_word;
	fpu_flags_t  dec_flags;

	// ====================
	// Execute to result
	// ====================
	logic                   exe_valid;
	logic                   exe_sign;
	logic signed [9:0]      exe_exp;
	logic [24+GUARD_BITS:0] exe_sum;
	logic                   exe_special;
	f32_t                   exe_special_word;
	fpu_flags_t             exe_flags;

	fpu_f32_decode u_decode (
		.clk              (clk),
		.arst_n           (arst_n),
		.in_valid         (in_valid),
		.op               (op),
		.a                (a),
		.b                (b),
		.dec_valid        (dec_valid),
		.dec_sign_a       (dec_sign_a),
		.dec_sign_b       (dec_sign_b),
		.dec_exp_a        (dec_exp_a),
		.dec_exp_b        (dec_exp_b),
		.dec_sig_a        (dec_sig_a),
		.dec_sig_b        (dec_sig_b),
		.dec_special      (dec_special),
		.dec_special_word (dec_special_word),
		.dec_flags        (dec_flags)
	);

	// Guard width sets the sum bus between execute and result
	fpu_f32_execute #(
		.GUARD_BITS (GUARD_BITS)
	) u_execute (
		.clk              (clk),
		.arst_n           (arst_n),
		.dec_valid        (dec_valid),
		.dec_sign_a       (dec_sign_a),
		.dec_sign_b       (dec_sign_b),
		.dec_exp_a        (dec_exp_a),
		.dec_exp_b        (dec_exp_b),
		.dec_sig_a        (dec_sig_a),
		.dec_sig_b        (dec_sig_b),
		.dec_special      (dec_special),
		.dec_special_word (dec_special_word),
		.dec_flags        (dec_flags),
		.exe_valid        (exe_valid),
		.exe_sign         (exe_sign),
		.exe_exp          (exe_exp),
		.exe_sum          (exe_sum),
		.exe_special      (exe_special),
		.exe_special_word (exe_special_word),
		.exe_flags        (exe_flags)
	);

	fpu_f32_result #(
		.GUARD_BITS (GUARD_BITS)
	) u_result (
		.clk              (clk),
		.arst_n           (arst_n),
		.exe_valid        (exe_valid),
		.exe_sign         (exe_sign),
		.exe_exp          (exe_exp),
		.exe_sum          (exe_sum),
		.exe_special      (exe_special),
		.exe_special_word (exe_special_word),
		.exe_flags        (exe_flags),
		.out_valid        (out_valid),
		.result           (result),
		.flags            (flags)
	);

endmodule

// File: tests/fpu_f32_add_properties.sv
/* Bound assertions on strobe latency, reset state and idle flags */
`timescale 1ns/1ps

module fpu_f32_add_properties
	import fpu_op_pkg::*;
(
	input logic       clk,
	input logic       arst_n,
	input logic       in_valid,
	input logic       out_valid,
	input fpu_flags_t flags
);

	// Every strobe comes out three cycles later
	a_valid_follows: assert property (@(posedge clk) disable iff (!arst_n)
		$past(in_valid, 3) |-> out_valid)
		else $error("out_valid missing three cycles after in_valid");

	// And nothing comes out without one
	a_valid_origin: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid |-> $past(in_valid, 3))
		else $error("out_valid without in_valid three cycles earlier");

	a_reset_quiet: assert property (@(posedge clk) !arst_n |-> !out_valid)
		else $error("out_valid high during reset");

	// Idle cycles carry no flags
	a_idle_flags: assert property (@(posedge clk) disable iff (!arst_n)
		!out_valid |-> flags == '0)
		else $error("flags set while out_valid is low");

endmodule

bind fpu_f32_add fpu_f32_add_properties u_properties (
	.clk       (clk),
	.arst_n    (arst_n),
	.in_valid  (in_valid),
	.out_valid (out_valid),
	.flags     (flags)
);

// File: tests/fpu_f32_add_tb.sv
/* Testbench for the f32 add/sub pipeline with file-driven vectors,
   in-order result checks and a cycle-count timeout */
`timescale 1ns/1ps

module fpu_f32_add_tb
	import fpu_f32_pkg::*, fpu_op_pkg::*;
();

	localparam string STIM_FILE = "tests/fpu_f32_add_stimulus.txt";

	logic       clk;
	logic       arst_n;
	logic       in_valid;
	fpu_op_t    op;
	f32_t       a;
	f32_t       b;
	logic       out_valid;
	f32_t       result;
	fpu_flags_t flags;

	// Vectors as read from the stimulus file
	fpu_op_t    vec_op[$];
	f32_t       vec_a[$];
	f32_t       vec_b[$];
	f32_t       vec_res[$];
	fpu_flags_t vec_flags[$];

	// Expected results still in flight, oldest first
	f32_t       pend_res[$];
	fpu_flags_t pend_flags[$];

	f32_t       want_res;
	fpu_flags_t want_flags;
	int         cycle_count;
	int         cycle_limit;
	int         checked;

	fpu_f32_add #(
		.GUARD_BITS (3)
	) uut (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.op        (op),
		.a         (a),
		.b         (b),
		.out_valid (out_valid),
		.result    (result),
		.flags     (flags)
	);

	// 20 ns clock
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ====================
	// Checks
	// ====================
	task automatic stop_with_failure();
		$display("Some tests failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_result(input f32_t expected, input f32_t actual);
		if (actual.raw !== expected.raw) begin
			$display("[FAIL] %0t ns result: expected %h, got %h",
				$time, expected.raw, actual.raw);
			stop_with_failure();
		end
	endtask

	task automatic check_flags(input fpu_flags_t expected, input fpu_flags_t actual);
		if (actual !== expected) begin
			$display("[FAIL] %0t ns flags: expected %b, got %b", $time, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_level(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("[FAIL] %0t ns %s: expected %b, got %b", $time, name, expected, actual);
			stop_with_failure();
		end
	endtask

	// ====================
	// Stimulus
	// ====================
	task automatic load_vectors();
		int          fd;
		int          n;
		string       text_line;
		int unsigned f_op;
		int unsigned f_a;
		int unsigned f_b;
		int unsigned f_res;
		int unsigned f_flags;
		f32_t        word;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("Cannot open the stimulus file %s", STIM_FILE);
			stop_with_failure();
		end else begin
			while (!$feof(fd)) begin
				text_line = "";
				n = $fgets(text_line, fd);
				// Blank lines and # comment lines hold no vector
				if (n > 1 && text_line[0] != "#") begin
					n = $sscanf(text_line, "%h %h %h %h %h",
						f_op, f_a, f_b, f_res, f_flags);
					if (n == 5) begin
						vec_op.push_back(fpu_op_t'(f_op[0]));
						word.raw = f_a;
						vec_a.push_back(word);
						word.raw = f_b;
						vec_b.push_back(word);
						word.raw = f_res;
						vec_res.push_back(word);
						vec_flags.push_back(fpu_flags_t'(f_flags[3:0]));
					end
				end
			end
			$fclose(fd);
			if (vec_a.size() == 0) begin
				$display("The stimulus file holds no vectors");
				stop_with_failure();
			end
		end
	endtask

	// One strobe cycle, expected pair queued at issue
	task automatic issue_vector(input int idx);
		@(posedge clk);
		#1;
		in_valid = 1'b1;
		op = vec_op[idx];
		a = vec_a[idx];
		b = vec_b[idx];
		pend_res.push_back(vec_res[idx]);
		pend_flags.push_back(vec_flags[idx]);
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		op = FPU_OP_ADD;
		a = '0;
		b = '0;
	endtask

	// ====================
	// Monitor and timeout
	// ====================
	// Outputs sampled mid-cycle, well away from the rising edge
	always @(negedge clk) begin
		if (arst_n) begin
			if (out_valid) begin
				if (pend_res.size() == 0) begin
					$display("out_valid rose at %0t ns with no operation outstanding", $time);
					stop_with_failure();
				end else begin
					want_res = pend_res.pop_front();
					want_flags = pend_flags.pop_front();
					check_result(want_res, result);
					check_flags(want_flags, flags);
					checked = checked + 1;
				end
			end else begin
				// Idle outputs read as zero
				check_result('0, result);
				check_flags('0, flags);
			end
		end
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			$display("The run did not finish within %0d clock cycles", cycle_limit);
			stop_with_failure();
		end
	end

	initial begin
		int gap;
		int half;
		arst_n = 1'b0;
		in_valid = 1'b0;
		op = FPU_OP_ADD;
		a = '0;
		b = '0;
		cycle_count = 0;
		cycle_limit = 0;
		checked = 0;
		load_vectors();
		// Two clocks per vector covers gaps, with slack for reset and drain
		cycle_limit = 2 * vec_a.size() + 20;
		half = vec_a.size() / 2;

		repeat (2) @(posedge clk);
		#1;
		arst_n = 1'b1;
		check_level("out_valid", 1'b0, out_valid);
		check_result('0, result);
		check_flags('0, flags);
		// Quiet cycles before the first strobe
		repeat (2) idle_cycle();

		// First half back to back, second half with one or two idle cycles
		for (int i = 0; i < vec_a.size(); i++) begin
			gap = (i >= half) ? 1 + (i % 2) : 0;
			repeat (gap) idle_cycle();
			issue_vector(i);
		end
		idle_cycle();

		// Last result is due three cycles after its strobe
		repeat (3) @(posedge clk);
		// Extra cycles to expose stray strobes
		repeat (4) @(posedge clk);

		if (pend_res.size() != 0 || checked != vec_a.size()) begin
			$display("Only %0d of %0d results came out", checked, vec_a.size());
			stop_with_failure();
		end else begin
			$display("Checked %0d results", checked);
			$display("All tests passed");
			$finish;
		end
	end

endmodule

// File: tests/fpu_f32_add_stimulus.txt
# op a b result flags, all hex, op 0 is add and 1 is sub
# flags bits from 3 down to 0 are invalid overflow underflow inexact
0 3F800000 3F800000 40000000 0
0 3FC00000 40200000 40800000 0
1 40400000 3F800000 40000000 0
1 3F800000 40000000 BF800000 0
0 42C80000 3E800000 42C88000 0
0 41200000 3DCCCCCD 4121999A 1
1 41200000 3DCCCCCD 411E6666 1
0 3F800000 33800000 3F800000 1
0 3F800001 33800000 3F800002 1
0 3F800000 33C00000 3F800001 1
0 3F800000 33000000 3F800000 1
1 3F800000 33000000 3F800000 1
1 3F800001 3F800000 34000000 0
1 3F800000 3F800000 00000000 0
0 C0000000 40000000 00000000 0
0 80000000 80000000 80000000 0
0 7FC00000 3F800000 7FC00000 0
0 7F800001 3F800000 7FC00000 8
0 7F800000 3F800000 7F800000 0
1 3F800000 7F800000 FF800000 0
1 7F800000 7F800000 7FC00000 8
0 7F800000 FF800000 7FC00000 8
0 7F7FFFFF 7F7FFFFF 7F800000 5
0 FF7FFFFF FF7FFFFF FF800000 5
0 7F7FFFFF 73000000 7F800000 5
1 00C00000 00800000 00000000 2
1 80C00000 80800000 80000000 2
0 00000001 3F800000 3F800000 0
0 00400000 00400000 00000000 0

// File: build.f
verilog/fpu_f32_pkg.sv
verilog/fpu_op_pkg.sv
verilog/fpu_f32_decode.sv
verilog/fpu_f32_execute.sv
verilog/fpu_f32_result.sv
verilog/fpu_f32_add.sv
tests/fpu_f32_add_properties.sv
tests/fpu_f32_add_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the f32 add/sub testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module fpu_f32_add_tb \
	-f build.f \
	-o fpu_f32_add_sim

out=$(./obj_dir/fpu_f32_add_sim 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "All tests passed"; then
	exit 0
else
	exit 1
fi
